// ==== logic/adc_sample_pkg.sv ====
package adc_sample_pkg;

    // raw converter sample
    localparam int SAMPLE_W = 12;

    // samples stored in one word FIFO entry
    localparam int SAMPLES_PER_WORD = 3;

    localparam int WORD_W = SAMPLE_W * SAMPLES_PER_WORD;  // 36

    // host side readout width
    localparam int BYTE_W = 8;

    // high-res readout walks two words per pass
    // 72 bits give 9 bytes and 6 samples
    localparam int HIRES_BYTES = (2 * WORD_W) / BYTE_W;

endpackage

// ==== logic/capture_ctrl_pkg.sv ====
package capture_ctrl_pkg;

    // capture sequencing
    //   IDLE             nothing written to the fast FIFO
    //   PRESAMP_FILLING  armed, pretrigger window still growing
    //   PRESAMP_FULL     window full, one discard per write
    //   TRIGGERED        fast FIFO drains into the packer
    typedef enum logic [1:0] {
        IDLE            = 2'd0,
        PRESAMP_FILLING = 2'd1,
        PRESAMP_FULL    = 2'd2,
        TRIGGERED       = 2'd3
    } capture_state_t;

    // presample count, must stay below the fast FIFO depth
    localparam int PRESAMPLE_W = 10;

    // samples skipped between kept ones
    localparam int DOWNSAMPLE_W = 13;

endpackage

// ==== logic/sample_fifo.sv ====
module sample_fifo #(
    parameter int DATA_W = 12,
    parameter int DEPTH  = 256
) (
    input  logic              adc_sampleclk,
    input  logic              reset,
    input  logic              flush_i,
    input  logic              wr_en_i,
    input  logic [DATA_W-1:0] din_i,
    input  logic              rd_en_i,
    output logic [DATA_W-1:0] dout_o,
    output logic              full_o,
    output logic              empty_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [AW:0]       count;
    logic              do_wr;
    logic              do_rd;

    assign full_o  = (count == DEPTH);
    assign empty_o = (count == 0);

    // overflow and underflow are silently dropped
    assign do_wr = wr_en_i && !full_o;
    assign do_rd = rd_en_i && !empty_o;

    // head word visible while not empty
    assign dout_o = mem[rd_ptr];

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== logic/presample_ctrl.sv ====
module presample_ctrl (
    input  logic                                     adc_sampleclk,
    input  logic                                     reset,
    input  logic                                     arm_i,
    input  logic                                     adc_capture_go_i,
    input  logic                                     adc_write_mask_i,
    input  logic [capture_ctrl_pkg::DOWNSAMPLE_W-1:0] downsample_i,
    input  logic [capture_ctrl_pkg::PRESAMPLE_W-1:0]  presample_i,
    input  logic                                     fast_full_i,
    input  logic                                     fast_empty_i,
    input  logic                                     slow_full_i,
    output logic                                     arm_flush_o,
    output logic                                     fast_wr_o,
    output logic                                     fast_rd_o,
    output logic                                     sample_take_o,
    output logic                                     adc_capture_stop_o
);

    capture_ctrl_pkg::capture_state_t state;

    logic                                     arm_r;
    logic                                     arm_r2;
    logic [capture_ctrl_pkg::DOWNSAMPLE_W-1:0] downsample_ctr;
    logic                                     downsample_mark;
    logic [capture_ctrl_pkg::PRESAMPLE_W-1:0]  presample_cnt;
    logic                                     kept_read;
    logic                                     discard_read;

    // arm edge, pulse lands two cycles after arm_i rises
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r       <= 1'b0;
            arm_r2      <= 1'b0;
            arm_flush_o <= 1'b0;
        end else begin
            arm_r       <= arm_i;
            arm_r2      <= arm_r;
            arm_flush_o <= arm_r && !arm_r2;
        end
    end

    // keeps one sample in every downsample_i+1
    always_ff @(posedge adc_sampleclk) begin
        if (reset || arm_flush_o || state == capture_ctrl_pkg::IDLE) begin
            downsample_ctr  <= '0;
            downsample_mark <= 1'b0;
        end else if (downsample_ctr == downsample_i) begin
            downsample_ctr  <= '0;
            downsample_mark <= 1'b1;
        end else begin
            downsample_ctr  <= downsample_ctr + 1'b1;
            downsample_mark <= 1'b0;
        end
    end

    assign fast_wr_o = downsample_mark && adc_write_mask_i && !fast_full_i &&
                       (state != capture_ctrl_pkg::IDLE);

    // after trigger every available sample goes to the packer
    assign kept_read = (state == capture_ctrl_pkg::TRIGGERED) && !fast_empty_i && !slow_full_i;

    // pretrigger window slides, oldest sample dropped per new one
    assign discard_read = (state == capture_ctrl_pkg::PRESAMP_FULL) && fast_wr_o &&
                          !adc_capture_go_i && !fast_empty_i;

    assign fast_rd_o     = kept_read || discard_read;
    assign sample_take_o = kept_read;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state         <= capture_ctrl_pkg::IDLE;
            presample_cnt <= '0;
        end else begin
            case (state)
                capture_ctrl_pkg::IDLE: begin
                    presample_cnt <= '0;
                    if (arm_i) begin
                        state <= capture_ctrl_pkg::PRESAMP_FILLING;
                    end else if (adc_capture_go_i) begin
                        state <= capture_ctrl_pkg::TRIGGERED;
                    end
                end
                capture_ctrl_pkg::PRESAMP_FILLING: begin
                    if (arm_flush_o) begin  // FIFO just cleared, count again
                        presample_cnt <= '0;
                    end else if (adc_capture_go_i) begin
                        state <= capture_ctrl_pkg::TRIGGERED;
                    end else if (fast_wr_o) begin
                        presample_cnt <= presample_cnt + 1'b1;
                        if (presample_cnt + 1'b1 >= presample_i) begin
                            state <= capture_ctrl_pkg::PRESAMP_FULL;
                        end
                    end
                end
                capture_ctrl_pkg::PRESAMP_FULL: begin
                    if (arm_flush_o) begin
                        presample_cnt <= '0;
                        state         <= capture_ctrl_pkg::PRESAMP_FILLING;
                    end else if (adc_capture_go_i) begin
                        state <= capture_ctrl_pkg::TRIGGERED;
                    end
                end
                capture_ctrl_pkg::TRIGGERED: begin
                    if (!adc_capture_go_i) begin
                        state <= capture_ctrl_pkg::IDLE;
                    end
                end
                default: state <= capture_ctrl_pkg::IDLE;
            endcase
        end
    end

    // word FIFO backed up while capturing
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            adc_capture_stop_o <= 1'b0;
        end else begin
            adc_capture_stop_o <= (state == capture_ctrl_pkg::TRIGGERED) && slow_full_i;
        end
    end

endmodule

// ==== logic/word_packer.sv ====
module word_packer (
    input  logic                                adc_sampleclk,
    input  logic                                reset,
    input  logic                                flush_i,
    input  logic                                sample_take_i,
    input  logic [adc_sample_pkg::SAMPLE_W-1:0] sample_i,
    output logic                                slow_wr_o,
    output logic [adc_sample_pkg::WORD_W-1:0]   word_o
);

    localparam int CNT_W = $clog2(adc_sample_pkg::SAMPLES_PER_WORD);

    logic [CNT_W-1:0] take_cnt;
    logic             last_take;

    assign last_take = sample_take_i &&
                       (take_cnt == CNT_W'(adc_sample_pkg::SAMPLES_PER_WORD - 1));

    // first sample ends up in the top bits
    always_ff @(posedge adc_sampleclk) begin
        if (sample_take_i) begin
            word_o <= {word_o[adc_sample_pkg::WORD_W-adc_sample_pkg::SAMPLE_W-1:0], sample_i};
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_i) begin
            take_cnt  <= '0;  // partial word dropped
            slow_wr_o <= 1'b0;
        end else begin
            slow_wr_o <= last_take;
            if (last_take) begin
                take_cnt <= '0;
            end else if (sample_take_i) begin
                take_cnt <= take_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== logic/byte_unpacker.sv ====
module byte_unpacker (
    input  logic                              adc_sampleclk,
    input  logic                              reset,
    input  logic                              flush_i,
    input  logic                              low_res_i,
    input  logic                              low_res_lsb_i,
    input  logic                              fifo_read_fifoen_i,
    input  logic [adc_sample_pkg::WORD_W-1:0] slow_dout_i,
    input  logic                              slow_empty_i,
    output logic                              slow_rd_o,
    output logic [adc_sample_pkg::BYTE_W-1:0] fifo_read_data_o
);

    localparam int POS_W   = $clog2(adc_sample_pkg::HIRES_BYTES);
    localparam int NIB_W   = adc_sample_pkg::WORD_W - 4 * adc_sample_pkg::BYTE_W;
    localparam int LO_LAST = adc_sample_pkg::SAMPLES_PER_WORD - 1;
    localparam int HI_MID  = adc_sample_pkg::HIRES_BYTES / 2 - 1;  // last byte of word A
    localparam int HI_LAST = adc_sample_pkg::HIRES_BYTES - 1;

    logic [POS_W-1:0]                    pos;
    logic [NIB_W-1:0]                    nib_r;  // low bits of word A
    logic [adc_sample_pkg::SAMPLE_W-1:0] lo_sample;
    logic                                strobe;
    logic                                last_byte;

    assign strobe = fifo_read_fifoen_i && !slow_empty_i;  // strobe while empty ignored

    assign last_byte = low_res_i ? (pos >= POS_W'(LO_LAST))
                                 : (pos == POS_W'(HI_MID) || pos >= POS_W'(HI_LAST));

    // pop on the same edge as the last byte of the word
    assign slow_rd_o = strobe && last_byte;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || flush_i) begin
            pos <= '0;
        end else if (strobe) begin
            if (low_res_i ? (pos >= POS_W'(LO_LAST)) : (pos >= POS_W'(HI_LAST))) begin
                pos <= '0;
            end else begin
                pos <= pos + 1'b1;
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (strobe && !low_res_i && pos == POS_W'(HI_MID)) begin
            nib_r <= slow_dout_i[NIB_W-1:0];
        end
    end

    // low res, one sample per byte
    always_comb begin
        case (pos)
            POS_W'(0): lo_sample = slow_dout_i[35:24];
            POS_W'(1): lo_sample = slow_dout_i[23:12];
            default:   lo_sample = slow_dout_i[11:0];
        endcase
    end

    always_comb begin
        if (low_res_i) begin
            fifo_read_data_o = low_res_lsb_i ? lo_sample[7:0] : lo_sample[11:4];
        end else begin
            case (pos)
                POS_W'(0): fifo_read_data_o = slow_dout_i[35:28];
                POS_W'(1): fifo_read_data_o = slow_dout_i[27:20];
                POS_W'(2): fifo_read_data_o = slow_dout_i[19:12];
                POS_W'(3): fifo_read_data_o = slow_dout_i[11:4];
                POS_W'(4): fifo_read_data_o = {nib_r, slow_dout_i[35:32]};  // spans A and B
                POS_W'(5): fifo_read_data_o = slow_dout_i[31:24];
                POS_W'(6): fifo_read_data_o = slow_dout_i[23:16];
                POS_W'(7): fifo_read_data_o = slow_dout_i[15:8];
                default:   fifo_read_data_o = slow_dout_i[7:0];
            endcase
        end
    end

endmodule

// ==== logic/adc_capture_top.sv ====
module adc_capture_top #(
    parameter int FAST_DEPTH = 256,  // samples
    parameter int SLOW_DEPTH = 64    // packed words
) (
    input  logic                                     adc_sampleclk,
    input  logic                                     reset,
    input  logic [adc_sample_pkg::SAMPLE_W-1:0]      adc_datain_i,
    input  logic                                     adc_write_mask_i,
    input  logic                                     adc_capture_go_i,
    input  logic                                     arm_i,
    input  logic                                     low_res_i,
    input  logic                                     low_res_lsb_i,
    input  logic                                     fifo_read_fifoen_i,
    input  logic [capture_ctrl_pkg::PRESAMPLE_W-1:0]  presample_i,
    input  logic [capture_ctrl_pkg::DOWNSAMPLE_W-1:0] downsample_i,
    output logic                                     adc_capture_stop_o,
    output logic                                     fifo_read_fifoempty_o,
    output logic [adc_sample_pkg::BYTE_W-1:0]        fifo_read_data_o
);

    logic                                arm_flush;
    logic                                fast_wr;
    logic                                fast_rd;
    logic                                fast_full;
    logic                                fast_empty;
    logic [adc_sample_pkg::SAMPLE_W-1:0] fast_dout;
    logic                                sample_take;
    logic                                slow_wr;
    logic                                slow_rd;
    logic                                slow_full;
    logic                                slow_empty;
    logic [adc_sample_pkg::WORD_W-1:0]   slow_din;
    logic [adc_sample_pkg::WORD_W-1:0]   slow_dout;

    assign fifo_read_fifoempty_o = slow_empty;

    presample_ctrl u_presample_ctrl (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .arm_i              (arm_i),
        .adc_capture_go_i   (adc_capture_go_i),
        .adc_write_mask_i   (adc_write_mask_i),
        .downsample_i       (downsample_i),
        .presample_i        (presample_i),
        .fast_full_i        (fast_full),
        .fast_empty_i       (fast_empty),
        .slow_full_i        (slow_full),
        .arm_flush_o        (arm_flush),
        .fast_wr_o          (fast_wr),
        .fast_rd_o          (fast_rd),
        .sample_take_o      (sample_take),
        .adc_capture_stop_o (adc_capture_stop_o)
    );

    // pretrigger and capture buffer, one sample per entry
    sample_fifo #(
        .DATA_W (adc_sample_pkg::SAMPLE_W),
        .DEPTH  (FAST_DEPTH)
    ) u_fast_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .flush_i       (arm_flush),
        .wr_en_i       (fast_wr),
        .din_i         (adc_datain_i),
        .rd_en_i       (fast_rd),
        .dout_o        (fast_dout),
        .full_o        (fast_full),
        .empty_o       (fast_empty)
    );

    word_packer u_word_packer (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .flush_i       (arm_flush),
        .sample_take_i (sample_take),
        .sample_i      (fast_dout),
        .slow_wr_o     (slow_wr),
        .word_o        (slow_din)
    );

    sample_fifo #(
        .DATA_W (adc_sample_pkg::WORD_W),
        .DEPTH  (SLOW_DEPTH)
    ) u_slow_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .flush_i       (arm_flush),
        .wr_en_i       (slow_wr),
        .din_i         (slow_din),
        .rd_en_i       (slow_rd),
        .dout_o        (slow_dout),
        .full_o        (slow_full),
        .empty_o       (slow_empty)
    );

    byte_unpacker u_byte_unpacker (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .flush_i            (arm_flush),
        .low_res_i          (low_res_i),
        .low_res_lsb_i      (low_res_lsb_i),
        .fifo_read_fifoen_i (fifo_read_fifoen_i),
        .slow_dout_i        (slow_dout),
        .slow_empty_i       (slow_empty),
        .slow_rd_o          (slow_rd),
        .fifo_read_data_o   (fifo_read_data_o)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD = 20
) (
    output logic adc_sampleclk_o
);

    initial begin
        adc_sampleclk_o = 1'b0;
    end

    always #(PERIOD / 2) adc_sampleclk_o = ~adc_sampleclk_o;  // free running

endmodule

// ==== tb/adc_capture_tb.sv ====
module adc_capture_tb;

    localparam int FAST_DEPTH = 256;
    localparam int SLOW_DEPTH = 64;
    // 4 captures of at most about 4000 cycles each plus margin
    localparam int MAX_CYCLES = 20000;

    logic                                     adc_sampleclk;
    logic                                     reset;
    logic [adc_sample_pkg::SAMPLE_W-1:0]      datain;
    logic                                     write_mask;
    logic                                     capture_go;
    logic                                     arm;
    logic                                     low_res;
    logic                                     low_res_lsb;
    logic                                     fifoen;
    logic [capture_ctrl_pkg::PRESAMPLE_W-1:0]  presample;
    logic [capture_ctrl_pkg::DOWNSAMPLE_W-1:0] downsample;
    logic                                     capture_stop;
    logic                                     fifoempty;
    logic [adc_sample_pkg::BYTE_W-1:0]        read_data;

    logic [15:0] lfsr_state;
    logic [11:0] ramp;
    int          mask_mode;  // 0 low, 1 high, 2 random
    logic        mask_hist [4096];
    int          value_errors;
    int          other_errors;
    int          cycle_count;
    logic [11:0] trig_value;
    logic [11:0] expected[$];
    logic [11:0] read_q[$];

    // reference model state
    logic                             m_arm_r;
    logic                             m_arm_r2;
    logic                             m_flush;
    logic                             m_mark;
    int                               m_ds_ctr;
    int                               m_pcnt;
    capture_ctrl_pkg::capture_state_t m_state;
    logic [11:0]                      m_fast[$];

    tb_clock_gen #(.PERIOD(20)) u_clock_gen (.adc_sampleclk_o(adc_sampleclk));

    adc_capture_top #(
        .FAST_DEPTH (FAST_DEPTH),
        .SLOW_DEPTH (SLOW_DEPTH)
    ) UUT (
        .adc_sampleclk         (adc_sampleclk),
        .reset                 (reset),
        .adc_datain_i          (datain),
        .adc_write_mask_i      (write_mask),
        .adc_capture_go_i      (capture_go),
        .arm_i                 (arm),
        .low_res_i             (low_res),
        .low_res_lsb_i         (low_res_lsb),
        .fifo_read_fifoen_i    (fifoen),
        .presample_i           (presample),
        .downsample_i          (downsample),
        .adc_capture_stop_o    (capture_stop),
        .fifo_read_fifoempty_o (fifoempty),
        .fifo_read_data_o      (read_data)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        int k;
        v = 0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    task automatic report_mismatch(input string msg);
        value_errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("summary: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // one clock with ramp and mask changed on the falling edge
    task automatic step();
        @(negedge adc_sampleclk);
        ramp   = ramp + 1'b1;
        datain = ramp;
        case (mask_mode)
            0:       write_mask = 1'b0;
            1:       write_mask = 1'b1;
            default: write_mask = rand_bits(1);
        endcase
        mask_hist[ramp] = write_mask;
    endtask

    task automatic wait_not_empty();
        while (fifoempty !== 1'b0) begin
            step();
        end
    endtask

    task automatic read_hires_byte(output logic [7:0] b);
        wait_not_empty();
        b      = read_data;
        fifoen = 1'b1;
        step();
        fifoen = 1'b0;
    endtask

    // same byte seen through both muxes before the strobe
    task automatic read_lowres_byte(output logic [7:0] msb, output logic [7:0] lsb);
        low_res_lsb = 1'b0;
        step();
        wait_not_empty();
        msb         = read_data;
        low_res_lsb = 1'b1;
        step();
        lsb    = read_data;
        fifoen = 1'b1;
        step();
        fifoen      = 1'b0;
        low_res_lsb = 1'b0;
    endtask

    task automatic read_groups(input int cap, input bit hires, input int groups);
        logic [71:0] exp72;
        logic [71:0] got72;
        logic [7:0]  b;
        logic [7:0]  lsb;
        logic [11:0] s;
        int          g;
        int          i;
        for (g = 0; g < groups; g++) begin
            for (i = 0; i < 6; i++) begin
                exp72 = {exp72[59:0], expected[6*g+i]};
            end
            if (hires) begin
                for (i = 0; i < 9; i++) begin
                    read_hires_byte(b);
                    got72 = {got72[63:0], b};
                    if (b !== exp72[71-8*i -: 8]) begin
                        report_mismatch($sformatf("capture %0d group %0d byte %0d got %02h exp %02h",
                                                  cap, g, i, b, exp72[71-8*i -: 8]));
                    end
                end
                for (i = 0; i < 6; i++) begin
                    read_q.push_back(got72[71-12*i -: 12]);
                end
            end else begin
                for (i = 0; i < 6; i++) begin
                    s = expected[6*g+i];
                    read_lowres_byte(b, lsb);
                    if (b !== s[11:4] || lsb !== s[7:0]) begin
                        report_mismatch($sformatf("capture %0d sample %0d got %02h/%02h exp %03h",
                                                  cap, 6*g+i, b, lsb, s));
                    end
                    read_q.push_back({b, lsb[3:0]});
                end
            end
        end
    endtask

    task automatic run_capture(input int cap, input bit hires, input bit rand_mask,
                               input bit fill_slow, input int ds, input int p);
        int          below;
        int          i;
        logic [11:0] diff;
        low_res    = !hires;
        downsample = ds;
        presample  = p;
        read_q.delete();
        arm = 1'b1;
        step();
        step();
        arm = 1'b0;
        repeat (6) step();  // flush lands while mask is low
        mask_mode = rand_mask ? 2 : 1;
        while (m_state != capture_ctrl_pkg::PRESAMP_FULL) begin
            step();
        end
        repeat (rand_bits(3) + 1) step();  // window slides a bit
        capture_go = 1'b1;
        trig_value = datain;
        if (fill_slow) begin
            while (capture_stop !== 1'b1) begin
                step();
            end
            // a full word FIFO has taken SLOW_DEPTH words of three samples
            if (m_fast.size() < 3 * SLOW_DEPTH) begin
                report_mismatch($sformatf("capture %0d stop after %0d samples exp %0d or more",
                                          cap, m_fast.size(), 3 * SLOW_DEPTH));
            end
        end else begin
            repeat (60) step();
        end
        mask_mode = 0;
        step();
        step();
        expected = m_fast;
        read_groups(cap, hires, expected.size() / 6);
        capture_go = 1'b0;
        step();
        step();
        if (fill_slow && capture_stop !== 1'b0) begin
            report_mismatch($sformatf("capture %0d stop still high after readout", cap));
        end
        below = 0;
        for (i = 0; i < read_q.size(); i++) begin
            diff = trig_value - read_q[i];
            if (diff != 0 && diff < 12'd2048) begin
                below++;
            end
            if (mask_hist[read_q[i]] !== 1'b1) begin
                report_mismatch($sformatf("capture %0d sample %03h from masked cycle", cap, read_q[i]));
            end
            diff = read_q[i] - read_q[(i > 0) ? i - 1 : 0];
            if (!rand_mask && i > 0 && diff != ds + 1) begin
                report_mismatch($sformatf("capture %0d sample %0d step %0d exp %0d",
                                          cap, i, diff, ds + 1));
            end
        end
        if (below != p) begin
            report_mismatch($sformatf("capture %0d %0d pretrigger samples exp %0d", cap, below, p));
        end
    endtask

    always @(posedge adc_sampleclk) begin : model
        logic wr;
        if (reset) begin
            m_arm_r  = 1'b0;
            m_arm_r2 = 1'b0;
            m_flush  = 1'b0;
            m_mark   = 1'b0;
            m_ds_ctr = 0;
            m_pcnt   = 0;
            m_state  = capture_ctrl_pkg::IDLE;
            m_fast.delete();
        end else begin
            // stimulus keeps the fast FIFO well below full after the trigger
            wr = m_mark && write_mask && (m_state != capture_ctrl_pkg::IDLE) &&
                 (m_state == capture_ctrl_pkg::TRIGGERED || m_fast.size() < FAST_DEPTH);
            if (m_flush) begin
                m_fast.delete();
            end else if (wr) begin
                m_fast.push_back(datain);
                if (m_state == capture_ctrl_pkg::PRESAMP_FULL && !capture_go) begin
                    m_fast.delete(0);  // oldest leaves the window
                end
            end
            if (m_flush || m_state == capture_ctrl_pkg::IDLE) begin
                m_ds_ctr = 0;
                m_mark   = 1'b0;
            end else if (m_ds_ctr == downsample) begin
                m_ds_ctr = 0;
                m_mark   = 1'b1;
            end else begin
                m_ds_ctr++;
                m_mark = 1'b0;
            end
            case (m_state)
                capture_ctrl_pkg::IDLE: begin
                    m_pcnt = 0;
                    if (arm) begin
                        m_state = capture_ctrl_pkg::PRESAMP_FILLING;
                    end else if (capture_go) begin
                        m_state = capture_ctrl_pkg::TRIGGERED;
                    end
                end
                capture_ctrl_pkg::PRESAMP_FILLING: begin
                    if (m_flush) begin
                        m_pcnt = 0;
                    end else if (capture_go) begin
                        m_state = capture_ctrl_pkg::TRIGGERED;
                    end else if (wr) begin
                        m_pcnt++;
                        if (m_pcnt >= presample) begin
                            m_state = capture_ctrl_pkg::PRESAMP_FULL;
                        end
                    end
                end
                capture_ctrl_pkg::PRESAMP_FULL: begin
                    if (m_flush) begin
                        m_pcnt  = 0;
                        m_state = capture_ctrl_pkg::PRESAMP_FILLING;
                    end else if (capture_go) begin
                        m_state = capture_ctrl_pkg::TRIGGERED;
                    end
                end
                default: begin
                    if (!capture_go) begin
                        m_state = capture_ctrl_pkg::IDLE;
                    end
                end
            endcase
            m_flush  = m_arm_r && !m_arm_r2;  // registered arm rising edge
            m_arm_r2 = m_arm_r;
            m_arm_r  = arm;
        end
    end

    always @(posedge adc_sampleclk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycle_count);
            other_errors++;
            finish_run();
        end
    end

    initial begin
        int i;
        reset        = 1'b1;
        datain       = '0;
        write_mask   = 1'b0;
        capture_go   = 1'b0;
        arm          = 1'b0;
        low_res      = 1'b0;
        low_res_lsb  = 1'b0;
        fifoen       = 1'b0;
        presample    = '0;
        downsample   = '0;
        lfsr_state   = 16'd17;
        ramp         = '0;
        mask_mode    = 0;
        value_errors = 0;
        other_errors = 0;
        cycle_count  = 0;
        for (i = 0; i < 4096; i++) begin
            mask_hist[i] = 1'b0;
        end
        repeat (10) step();
        reset = 1'b0;
        repeat (3) step();
        run_capture(1, 1'b1, 1'b0, 1'b0, 0, 4 + rand_bits(6) % 57);                   // window
        run_capture(2, 1'b0, 1'b0, 1'b0, 1 + rand_bits(3) % 5, 4 + rand_bits(6) % 57);
        run_capture(3, 1'b0, 1'b1, 1'b0, 0, 4 + rand_bits(6) % 57);                   // random mask
        run_capture(4, 1'b1, 1'b0, 1'b1, 0, 4 + rand_bits(6) % 57);                   // word FIFO fills
        finish_run();
    end

endmodule

// ==== adc_capture_top.f ====
logic/adc_sample_pkg.sv
logic/capture_ctrl_pkg.sv
logic/sample_fifo.sv
logic/presample_ctrl.sv
logic/word_packer.sv
logic/byte_unpacker.sv
logic/adc_capture_top.sv
tb/tb_clock_gen.sv
tb/adc_capture_tb.sv
